/* hdl/cpuParams.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data and address width
`define WORD_WIDTH 16

// architectural registers r0..r3
`define REG_COUNT 4

// first fetch address after reset
`define RESET_PC 16'h0000

// words in the simulation memory
`define MEM_DEPTH 256

`endif

/* hdl/isaPkg.sv */
`include "cpuParams.svh"

package isaPkg;

    typedef logic [`WORD_WIDTH-1:0] wordT;
    typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;
    typedef logic [7:0] immT;

    // instr[15:12]
    typedef enum logic [3:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opAdi   = 4'd4,
        opOri   = 4'd5,
        opLhi   = 4'd6,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opRtype = 4'd15
    } opcodeT;

    // instr[5:0], only meaningful for opRtype
    typedef enum logic [5:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOrr = 6'd3,
        fnWwd = 6'd28,
        fnHlt = 6'd29
    } funcT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluPassA
    } aluOpT;

endpackage

/* hdl/pipePkg.sv */
package pipePkg;

    // control word carried down the pipe, zero for a bubble
    typedef struct packed {
        logic regDst;
        logic isJump;
        logic isBranch;
        logic aluSrc;
        logic isAlu;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic regWrite;
        logic wwd;
        logic hlt;
    } ctrlT;

    typedef enum logic [1:0] {
        fromReg = 2'd0,
        fromMem = 2'd1,
        fromWb  = 2'd2
    } fwdSelT;

    typedef logic stageValidT;

endpackage

/* hdl/wbBusIf.sv */
`timescale 1ns/1ps

// writeback result, seen by the register file and the forwarding logic
interface wbBusIf import isaPkg::*; ();

    logic   wbValid;
    logic   regWrite;
    regIdxT rd;
    wordT   data;

    modport writer (output wbValid, output regWrite, output rd, output data);
    modport reader (input wbValid, input regWrite, input rd, input data);

endinterface

/* hdl/regFile.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module regFile import isaPkg::*; (
    input  logic   Clk,
    input  logic   rstN,
    input  regIdxT rs,
    input  regIdxT rt,
    output wordT   rsData,
    output wordT   rtData,
    wbBusIf.reader wb
);

    wordT regs [`REG_COUNT];
    logic wrEn;

    assign wrEn = wb.wbValid && wb.regWrite;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // decode sees a value written in the same cycle
    assign rsData = (wrEn && wb.rd == rs) ? wb.data : regs[rs];
    assign rtData = (wrEn && wb.rd == rt) ? wb.data : regs[rt];

endmodule

/* hdl/controlDecode.sv */
`timescale 1ns/1ps

module controlDecode import isaPkg::*, pipePkg::*; (
    input  wordT   instr,
    input  logic   valid,
    output ctrlT   ctrl,
    output regIdxT rd,
    output logic   useRs,
    output logic   useRt
);

    opcodeT opcode;
    funcT   func;

    assign opcode = opcodeT'(instr[15:12]);
    assign func   = funcT'(instr[5:0]);

    always_comb begin
        ctrl  = '0;
        useRs = 1'b0;
        useRt = 1'b0;
        if (valid) begin
            case (opcode)
                opRtype: begin
                    case (func)
                        fnAdd, fnSub, fnAnd, fnOrr: begin
                            ctrl.regDst   = 1'b1;
                            ctrl.isAlu    = 1'b1;
                            ctrl.regWrite = 1'b1;
                            useRs         = 1'b1;
                            useRt         = 1'b1;
                        end
                        fnWwd: begin
                            ctrl.wwd = 1'b1;
                            useRs    = 1'b1;
                        end
                        fnHlt: ctrl.hlt = 1'b1;
                        default: ;
                    endcase
                end
                opAdi, opOri: begin
                    ctrl.aluSrc   = 1'b1;
                    ctrl.isAlu    = 1'b1;
                    ctrl.regWrite = 1'b1;
                    useRs         = 1'b1;
                end
                // immediate goes to the upper byte, no register source
                opLhi: begin
                    ctrl.aluSrc   = 1'b1;
                    ctrl.isAlu    = 1'b1;
                    ctrl.regWrite = 1'b1;
                end
                opLwd: begin
                    ctrl.aluSrc   = 1'b1;
                    ctrl.memRead  = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.regWrite = 1'b1;
                    useRs         = 1'b1;
                end
                opSwd: begin
                    ctrl.aluSrc   = 1'b1;
                    ctrl.memWrite = 1'b1;
                    useRs         = 1'b1;
                    useRt         = 1'b1;
                end
                opBne, opBeq: begin
                    ctrl.isBranch = 1'b1;
                    useRs         = 1'b1;
                    useRt         = 1'b1;
                end
                opJmp: ctrl.isJump = 1'b1;
                default: ;
            endcase
        end
    end

    // R-type writes rd, everything else writes rt
    assign rd = ctrl.regDst ? regIdxT'(instr[7:6]) : regIdxT'(instr[9:8]);

endmodule

/* hdl/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit import isaPkg::*; (
    input  opcodeT opcode,
    input  funcT   func,
    input  wordT   a,
    input  wordT   b,
    output wordT   result,
    output logic   branchTaken
);

    aluOpT aluOp;
    logic  isZero;

    always_comb begin
        case (opcode)
            opRtype: begin
                case (func)
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOrr:   aluOp = aluOr;
                    default: aluOp = aluPassA;
                endcase
            end
            opAdi, opLwd, opSwd: aluOp = aluAdd;
            opOri:               aluOp = aluOr;
            // branches compare by subtracting
            opBne, opBeq:        aluOp = aluSub;
            default:             aluOp = aluPassA;
        endcase
    end

    always_comb begin
        case (aluOp)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            default: result = a;
        endcase
    end

    assign isZero = (result == '0);

    // BEQ and BNE share opcode bits 3:1, bit 0 picks the zero sense
    always_comb begin
        branchTaken = (opcode[3:1] == 3'b000) && (isZero == opcode[0]);
        if (branchTaken) begin
            assert (opcode inside {opBne, opBeq})
                else $error("branch condition raised for opcode %0d", opcode);
        end
    end

endmodule

/* hdl/hazardForward.sv */
`timescale 1ns/1ps

module hazardForward import isaPkg::*, pipePkg::*; (
    input  logic   Clk,
    input  regIdxT exRs,
    input  regIdxT exRt,
    input  logic   exUseRs,
    input  logic   exUseRt,
    input  logic   memRegWrite,
    input  regIdxT memRd,
    wbBusIf.reader wb,
    input  regIdxT idRs,
    input  regIdxT idRt,
    input  logic   idUseRs,
    input  logic   idUseRt,
    input  logic   exMemRead,
    input  regIdxT exRd,
    output fwdSelT fwdA,
    output fwdSelT fwdB,
    output logic   loadStall
);

    logic wbWrites;

    assign wbWrites = wb.wbValid && wb.regWrite;

    // the memory stage holds the younger result, so it wins
    always_comb begin
        if (exUseRs && memRegWrite && memRd == exRs) begin
            fwdA = fromMem;
        end else if (exUseRs && wbWrites && wb.rd == exRs) begin
            fwdA = fromWb;
        end else begin
            fwdA = fromReg;
        end
        if (exUseRt && memRegWrite && memRd == exRt) begin
            fwdB = fromMem;
        end else if (exUseRt && wbWrites && wb.rd == exRt) begin
            fwdB = fromWb;
        end else begin
            fwdB = fromReg;
        end
    end

    // load data only exists in the memory stage, hold decode one cycle
    assign loadStall = exMemRead && ((idUseRs && idRs == exRd) || (idUseRt && idRt == exRd));

    // a load always reads its base register, so a stall implies a live execute slot
    aStallNeedsLoad: assert property (@(posedge Clk) loadStall |-> exUseRs)
        else $error("load-use stall raised with a bubble in execute");

endmodule

/* hdl/datapath.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module datapath import isaPkg::*, pipePkg::*; (
    input  logic   Clk,
    input  logic   rstN,
    output logic   instrRead,
    output wordT   instrAddr,
    input  wordT   instrData,
    output logic   dataRead,
    output logic   dataWrite,
    output wordT   dataAddr,
    output wordT   dataWdata,
    input  wordT   dataRdata,
    input  logic   memBusy,
    output wordT   idInstr,
    output logic   idValid,
    input  ctrlT   idCtrl,
    input  regIdxT idRd,
    input  logic   idUseRs,
    input  logic   idUseRt,
    output logic   halted,
    output wordT   numInst,
    output wordT   outputPort
);

    function automatic wordT fwdMux(fwdSelT sel, wordT regVal, wordT memVal, wordT wbVal);
        case (sel)
            fromMem: return memVal;
            fromWb:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    wordT pc;
    wordT pcPlusOne;
    wordT nextPc;

    stageValidT ifIdValid;
    wordT       ifIdInstr;
    wordT       ifIdPc;

    stageValidT idExValid;
    ctrlT       idExCtrl;
    logic       idExUseRs;
    logic       idExUseRt;
    wordT       idExPc;
    wordT       idExRsData;
    wordT       idExRtData;
    regIdxT     idExRs;
    regIdxT     idExRt;
    regIdxT     idExRd;
    opcodeT     idExOpcode;
    funcT       idExFunc;
    immT        idExImm;

    stageValidT exMemValid;
    ctrlT       exMemCtrl;
    wordT       exMemResult;
    wordT       exMemStoreData;
    regIdxT     exMemRd;

    stageValidT memWbValid;
    ctrlT       memWbCtrl;
    wordT       memWbData;
    regIdxT     memWbRd;

    regIdxT idRs;
    regIdxT idRt;
    wordT   idRsData;
    wordT   idRtData;
    logic   idJump;
    wordT   jumpTarget;

    fwdSelT fwdA;
    fwdSelT fwdB;
    wordT   exRsFwd;
    wordT   exRtFwd;
    wordT   immExt;
    wordT   aluB;
    wordT   aluResult;
    wordT   exResult;
    wordT   branchTarget;
    logic   aluBranch;
    logic   exFlush;
    logic   loadStall;

    wordT   memFwdData;
    logic   hltRetire;
    logic   advance;

    wbBusIf wbBus ();

    // fetch
    assign instrRead = !halted;
    assign instrAddr = pc;
    assign pcPlusOne = pc + 1'b1;

    // decode
    assign idInstr    = ifIdInstr;
    assign idValid    = ifIdValid;
    assign idRs       = regIdxT'(ifIdInstr[11:10]);
    assign idRt       = regIdxT'(ifIdInstr[9:8]);
    assign idJump     = idCtrl.isJump;
    assign jumpTarget = {ifIdPc[15:12], ifIdInstr[11:0]};

    regFile i_regFile (
        .Clk    (Clk),
        .rstN   (rstN),
        .rs     (idRs),
        .rt     (idRt),
        .rsData (idRsData),
        .rtData (idRtData),
        .wb     (wbBus.reader)
    );

    // execute
    assign exRsFwd = fwdMux(fwdA, idExRsData, memFwdData, wbBus.data);
    assign exRtFwd = fwdMux(fwdB, idExRtData, memFwdData, wbBus.data);
    assign immExt  = (idExOpcode == opOri) ? wordT'(idExImm) : wordT'($signed(idExImm));
    assign aluB    = idExCtrl.aluSrc ? immExt : exRtFwd;

    aluUnit i_aluUnit (
        .opcode      (idExOpcode),
        .func        (idExFunc),
        .a           (exRsFwd),
        .b           (aluB),
        .result      (aluResult),
        .branchTaken (aluBranch)
    );

    assign exResult = (idExCtrl.isAlu && idExOpcode == opLhi) ?
                      wordT'({idExImm, 8'h00}) : aluResult;
    // branch offset is relative to the instruction after the branch
    assign branchTarget = idExPc + immExt;
    assign exFlush      = idExCtrl.isBranch && aluBranch;

    hazardForward i_hazardForward (
        .Clk         (Clk),
        .exRs        (idExRs),
        .exRt        (idExRt),
        .exUseRs     (idExUseRs),
        .exUseRt     (idExUseRt),
        .memRegWrite (exMemCtrl.regWrite),
        .memRd       (exMemRd),
        .wb          (wbBus.reader),
        .idRs        (idRs),
        .idRt        (idRt),
        .idUseRs     (idUseRs),
        .idUseRt     (idUseRt),
        .exMemRead   (idExCtrl.memRead),
        .exRd        (idExRd),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .loadStall   (loadStall)
    );

    // memory, a store behind a retiring HLT must not reach memory
    assign hltRetire  = memWbValid && memWbCtrl.hlt;
    assign dataRead   = exMemCtrl.memRead;
    assign dataWrite  = exMemCtrl.memWrite && !hltRetire;
    assign dataAddr   = exMemResult;
    assign dataWdata  = exMemStoreData;
    assign memFwdData = exMemCtrl.memToReg ? dataRdata : exMemResult;

    // writeback
    assign wbBus.wbValid  = memWbValid;
    assign wbBus.regWrite = memWbCtrl.regWrite;
    assign wbBus.rd       = memWbRd;
    assign wbBus.data     = memWbData;

    assign advance = !memBusy && !halted;

    always_comb begin
        if (loadStall) begin
            nextPc = pc;
        end else if (exFlush) begin
            nextPc = branchTarget;
        end else if (idJump) begin
            nextPc = jumpTarget;
        end else begin
            nextPc = pcPlusOne;
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pc         <= `RESET_PC;
            halted     <= 1'b0;
            numInst    <= '0;
            outputPort <= '0;
            ifIdValid  <= 1'b0;
            idExValid  <= 1'b0;
            idExCtrl   <= '0;
            idExUseRs  <= 1'b0;
            idExUseRt  <= 1'b0;
            exMemValid <= 1'b0;
            exMemCtrl  <= '0;
            memWbValid <= 1'b0;
            memWbCtrl  <= '0;
        end else if (advance) begin
            if (memWbValid) begin
                numInst <= numInst + 1'b1;
                if (memWbCtrl.wwd) begin
                    outputPort <= memWbData;
                end
            end
            if (hltRetire) begin
                halted     <= 1'b1;
                ifIdValid  <= 1'b0;
                idExValid  <= 1'b0;
                idExCtrl   <= '0;
                idExUseRs  <= 1'b0;
                idExUseRt  <= 1'b0;
                exMemValid <= 1'b0;
                exMemCtrl  <= '0;
                memWbValid <= 1'b0;
                memWbCtrl  <= '0;
            end else begin
                pc <= nextPc;
                if (exFlush || idJump) begin
                    ifIdValid <= 1'b0;
                end else if (!loadStall) begin
                    ifIdValid <= instrRead;
                end
                if (exFlush || loadStall) begin
                    idExValid <= 1'b0;
                    idExCtrl  <= '0;
                    idExUseRs <= 1'b0;
                    idExUseRt <= 1'b0;
                end else begin
                    idExValid <= ifIdValid;
                    idExCtrl  <= idCtrl;
                    idExUseRs <= idUseRs;
                    idExUseRt <= idUseRt;
                end
                exMemValid <= idExValid;
                exMemCtrl  <= idExCtrl;
                memWbValid <= exMemValid;
                memWbCtrl  <= exMemCtrl;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (advance && !loadStall) begin
            ifIdInstr <= instrData;
            ifIdPc    <= pcPlusOne;
        end
        if (advance) begin
            idExPc         <= ifIdPc;
            idExRsData     <= idRsData;
            idExRtData     <= idRtData;
            idExRs         <= idRs;
            idExRt         <= idRt;
            idExRd         <= idRd;
            idExOpcode     <= opcodeT'(ifIdInstr[15:12]);
            idExFunc       <= funcT'(ifIdInstr[5:0]);
            idExImm        <= immT'(ifIdInstr[7:0]);
            exMemResult    <= exResult;
            exMemStoreData <= exRtFwd;
            exMemRd        <= idExRd;
            memWbData      <= memFwdData;
            memWbRd        <= exMemRd;
        end
    end

    aNoDualAccess: assert property (@(posedge Clk) disable iff (!rstN) !(dataRead && dataWrite))
        else $error("data read and write requested together");

    aHaltIsFinal: assert property (@(posedge Clk) disable iff (!rstN)
        halted |=> !memWbValid && $stable(numInst))
        else $error("instruction retired after halt");

endmodule

/* hdl/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop import isaPkg::*, pipePkg::*; (
    input  logic Clk,
    input  logic rstN,
    output logic instrRead,
    output wordT instrAddr,
    input  wordT instrData,
    output logic dataRead,
    output logic dataWrite,
    output wordT dataAddr,
    output wordT dataWdata,
    input  wordT dataRdata,
    input  logic memBusy,
    output logic halted,
    output wordT numInst,
    output wordT outputPort
);

    wordT   idInstr;
    logic   idValid;
    ctrlT   idCtrl;
    regIdxT idRd;
    logic   idUseRs;
    logic   idUseRt;

    datapath i_datapath (
        .Clk        (Clk),
        .rstN       (rstN),
        .instrRead  (instrRead),
        .instrAddr  (instrAddr),
        .instrData  (instrData),
        .dataRead   (dataRead),
        .dataWrite  (dataWrite),
        .dataAddr   (dataAddr),
        .dataWdata  (dataWdata),
        .dataRdata  (dataRdata),
        .memBusy    (memBusy),
        .idInstr    (idInstr),
        .idValid    (idValid),
        .idCtrl     (idCtrl),
        .idRd       (idRd),
        .idUseRs    (idUseRs),
        .idUseRt    (idUseRt),
        .halted     (halted),
        .numInst    (numInst),
        .outputPort (outputPort)
    );

    // decode-stage control, computed outside the datapath
    controlDecode i_controlDecode (
        .instr (idInstr),
        .valid (idValid),
        .ctrl  (idCtrl),
        .rd    (idRd),
        .useRs (idUseRs),
        .useRt (idUseRt)
    );

endmodule

/* testbench/tbCpu.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module tbCpu import isaPkg::*, pipePkg::*; ();

    localparam int addrBits = $clog2(`MEM_DEPTH);

    logic Clk;
    logic rstN;
    logic instrRead;
    wordT instrAddr;
    wordT instrData;
    logic dataRead;
    logic dataWrite;
    wordT dataAddr;
    wordT dataWdata;
    wordT dataRdata;
    logic memBusy;
    logic halted;
    wordT numInst;
    wordT outputPort;

    wordT        mem [`MEM_DEPTH];
    wordT        progWords [$];
    wordT        expOut [$];
    wordT        seenOut [$];
    wordT        lastOut;
    logic        busyOn;
    logic [31:0] rngState;
    int          busyCount;
    int          errorCount;
    int          checkCount;

    cpuTop i_cpuTop (
        .Clk        (Clk),
        .rstN       (rstN),
        .instrRead  (instrRead),
        .instrAddr  (instrAddr),
        .instrData  (instrData),
        .dataRead   (dataRead),
        .dataWrite  (dataWrite),
        .dataAddr   (dataAddr),
        .dataWdata  (dataWdata),
        .dataRdata  (dataRdata),
        .memBusy    (memBusy),
        .halted     (halted),
        .numInst    (numInst),
        .outputPort (outputPort)
    );

    always #50 Clk = ~Clk;

    // both memory ports read combinationally, data only on a read request
    always_comb begin
        instrData = mem[instrAddr[addrBits-1:0]];
        dataRdata = dataRead ? mem[dataAddr[addrBits-1:0]] : 'x;
    end

    // stores land mid-cycle, the DUT retires the access on the next rising edge
    always @(negedge Clk) begin
        if (rstN && dataWrite && !memBusy) begin
            mem[dataAddr[addrBits-1:0]] = dataWdata;
        end
    end

    always @(posedge Clk) begin
        #1;
        if (busyOn) begin
            rngState = xorshift(rngState);
            memBusy = (rngState[1:0] == 2'b00);
            if (memBusy) begin
                busyCount++;
            end
        end else begin
            memBusy = 1'b0;
        end
    end

    // record every new value on the output port
    always @(negedge Clk) begin
        if (rstN && outputPort !== lastOut) begin
            seenOut.push_back(outputPort);
            lastOut = outputPort;
        end
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic wordT encR(funcT fn, regIdxT rs, regIdxT rt, regIdxT rd);
        return {opRtype, rs, rt, rd, fn};
    endfunction

    function automatic wordT encI(opcodeT op, regIdxT rs, regIdxT rt, immT imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT encJ(logic [11:0] target);
        return {opJmp, target};
    endfunction

    // unused words get a pattern built from their address
    task automatic loadProgram();
        logic [addrBits-1:0] idx;
        for (int a = 0; a < `MEM_DEPTH; a++) begin
            idx = a[addrBits-1:0];
            if (a < progWords.size()) begin
                mem[a] = progWords[a];
            end else begin
                mem[a] = {~idx, idx};
            end
        end
    endtask

    task automatic applyReset();
        @(posedge Clk);
        #1;
        rstN = 1'b0;
        seenOut.delete();
        lastOut = '0;
        repeat (16) @(posedge Clk);
        #1;
        rstN = 1'b1;
    endtask

    task automatic waitForHalt(input string testName);
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < 2000) begin
            @(posedge Clk);
            #1;
            cycles++;
            if (halted) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("%s: the processor did not halt within 2000 cycles", testName);
            errorCount++;
        end
    endtask

    task automatic compareWord(input string what, input wordT got, input wordT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compareFlag(input string what, input stageValidT got, input stageValidT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkOutputs(input string testName);
        int n;
        n = (seenOut.size() < expOut.size()) ? seenOut.size() : expOut.size();
        compareWord({testName, " output count"}, wordT'(seenOut.size()), wordT'(expOut.size()));
        for (int i = 0; i < n; i++) begin
            compareWord($sformatf("%s output %0d", testName, i), seenOut[i], expOut[i]);
        end
    endtask

    task automatic buildAluProgram();
        progWords.delete();
        expOut.delete();
        progWords.push_back(encI(opLhi, 2'd0, 2'd1, 8'h12));    // r1 = 1200
        progWords.push_back(encI(opOri, 2'd1, 2'd1, 8'h34));    // r1 = 1234
        progWords.push_back(encR(fnWwd, 2'd1, 2'd0, 2'd0));
        progWords.push_back(encI(opAdi, 2'd1, 2'd2, 8'hfc));    // r2 = 1234 - 4
        progWords.push_back(encR(fnWwd, 2'd2, 2'd0, 2'd0));
        progWords.push_back(encR(fnAdd, 2'd1, 2'd2, 2'd3));     // r3 = 2464
        progWords.push_back(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        progWords.push_back(encR(fnAnd, 2'd3, 2'd1, 2'd0));     // r0 = 0024
        progWords.push_back(encR(fnWwd, 2'd0, 2'd0, 2'd0));
        progWords.push_back(encR(fnOrr, 2'd0, 2'd2, 2'd0));     // r0 = 1234
        progWords.push_back(encR(fnWwd, 2'd0, 2'd0, 2'd0));
        progWords.push_back(encR(fnSub, 2'd3, 2'd0, 2'd3));     // r3 = 1230
        progWords.push_back(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        // zero extended, so bit 7 stays low in the upper byte
        progWords.push_back(encI(opOri, 2'd0, 2'd2, 8'h80));
        progWords.push_back(encR(fnWwd, 2'd2, 2'd0, 2'd0));
        progWords.push_back(encR(fnHlt, 2'd0, 2'd0, 2'd0));
        expOut = '{16'h1234, 16'h1230, 16'h2464, 16'h0024, 16'h1234, 16'h1230, 16'h12b4};
    endtask

    task automatic buildControlProgram();
        progWords.delete();
        progWords.push_back(encI(opAdi, 2'd0, 2'd1, 8'h05));
        progWords.push_back(encI(opAdi, 2'd0, 2'd2, 8'h05));
        progWords.push_back(encI(opLhi, 2'd0, 2'd3, 8'hba));    // marker in r3
        progWords.push_back(encI(opBeq, 2'd1, 2'd2, 8'h02));    // taken, to 6
        progWords.push_back(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        progWords.push_back(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        progWords.push_back(encR(fnWwd, 2'd1, 2'd0, 2'd0));
        progWords.push_back(encI(opBne, 2'd1, 2'd2, 8'h02));    // not taken
        progWords.push_back(encI(opAdi, 2'd1, 2'd1, 8'h01));
        progWords.push_back(encR(fnWwd, 2'd1, 2'd0, 2'd0));
        progWords.push_back(encI(opBne, 2'd1, 2'd2, 8'h03));    // taken, to 14
        progWords.push_back(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        progWords.push_back(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        progWords.push_back(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        progWords.push_back(encI(opBeq, 2'd1, 2'd2, 8'h02));    // not taken
        progWords.push_back(encR(fnWwd, 2'd2, 2'd0, 2'd0));
        progWords.push_back(encJ(12'd19));
        progWords.push_back(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        progWords.push_back(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        progWords.push_back(encI(opAdi, 2'd2, 2'd2, 8'h10));
        progWords.push_back(encR(fnWwd, 2'd2, 2'd0, 2'd0));
        progWords.push_back(encR(fnHlt, 2'd0, 2'd0, 2'd0));
        expOut = '{16'h0005, 16'h0006, 16'h0005, 16'h0015};
    endtask

    task automatic runAluTest();
        buildAluProgram();
        loadProgram();
        applyReset();
        waitForHalt("alu test");
        checkOutputs("alu test");
        compareWord("alu test numInst", numInst, 16'd16);
    endtask

    task automatic runLoadStoreTest();
        progWords.delete();
        progWords.push_back(encI(opAdi, 2'd0, 2'd1, 8'h5a));
        progWords.push_back(encI(opLhi, 2'd0, 2'd2, 8'ha5));
        progWords.push_back(encR(fnOrr, 2'd2, 2'd1, 2'd2));     // r2 = a55a
        progWords.push_back(encI(opSwd, 2'd0, 2'd2, 8'h40));
        progWords.push_back(encI(opLwd, 2'd0, 2'd3, 8'h40));
        progWords.push_back(encR(fnAdd, 2'd3, 2'd1, 2'd3));     // load-use, a5b4
        progWords.push_back(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        progWords.push_back(encI(opAdi, 2'd0, 2'd1, 8'h42));
        progWords.push_back(encI(opSwd, 2'd1, 2'd3, 8'hff));    // address 41
        progWords.push_back(encI(opLwd, 2'd1, 2'd0, 8'hff));
        progWords.push_back(encR(fnSub, 2'd0, 2'd1, 2'd2));     // a5b4 - 0042
        progWords.push_back(encR(fnWwd, 2'd2, 2'd0, 2'd0));
        progWords.push_back(encR(fnHlt, 2'd0, 2'd0, 2'd0));
        expOut = '{16'ha5b4, 16'ha572};
        loadProgram();
        applyReset();
        waitForHalt("load/store test");
        checkOutputs("load/store test");
        compareWord("load/store test numInst", numInst, 16'd13);
        compareWord("memory word 40", mem[8'h40], 16'ha55a);
        compareWord("memory word 41", mem[8'h41], 16'ha5b4);
    endtask

    task automatic runControlTest();
        buildControlProgram();
        loadProgram();
        applyReset();
        waitForHalt("control test");
        checkOutputs("control test");
        compareWord("control test numInst", numInst, 16'd15);
        foreach (seenOut[i]) begin
            compareFlag($sformatf("control test output %0d free of marker", i),
                        stageValidT'(seenOut[i] != 16'hba00), 1'b1);
        end
    endtask

    task automatic runBusyTest();
        buildAluProgram();
        loadProgram();
        busyCount = 0;
        busyOn = 1'b1;
        applyReset();
        waitForHalt("busy test");
        busyOn = 1'b0;
        checkOutputs("busy test");
        compareWord("busy test numInst", numInst, 16'd16);
        compareFlag("busy test stalls applied", stageValidT'(busyCount > 0), 1'b1);
    endtask

    task automatic runHaltTest();
        wordT portAtHalt;
        wordT countAtHalt;
        buildControlProgram();
        loadProgram();
        applyReset();
        waitForHalt("halt test");
        compareWord("halt test numInst", numInst, 16'd15);
        portAtHalt = outputPort;
        countAtHalt = numInst;
        repeat (20) begin
            @(posedge Clk);
            #1;
            compareFlag("halted after HLT", halted, 1'b1);
            compareFlag("instrRead after HLT", instrRead, 1'b0);
            compareWord("outputPort after HLT", outputPort, portAtHalt);
            compareWord("numInst after HLT", numInst, countAtHalt);
        end
    endtask

    initial begin
        Clk = 1'b0;
        rstN = 1'b0;
        memBusy = 1'b0;
        busyOn = 1'b0;
        busyCount = 0;
        rngState = 32'h3a5859c1;
        errorCount = 0;
        checkCount = 0;
        lastOut = '0;
        progWords.delete();
        loadProgram();

        runAluTest();
        runLoadStoreTest();
        runControlTest();
        runBusyTest();
        runHaltTest();

        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+hdl
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/wbBusIf.sv
hdl/regFile.sv
hdl/controlDecode.sv
hdl/aluUnit.sv
hdl/hazardForward.sv
hdl/datapath.sv
hdl/cpuTop.sv
testbench/tbCpu.sv

/* Bender.yml */
package:
  name: pipeCpu

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/isaPkg.sv
      - hdl/pipePkg.sv
      - hdl/wbBusIf.sv
      - hdl/regFile.sv
      - hdl/controlDecode.sv
      - hdl/aluUnit.sv
      - hdl/hazardForward.sv
      - hdl/datapath.sv
      - hdl/cpuTop.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - testbench/tbCpu.sv
